// File: Bender.yml
package:
  name: tut_io

sources:
  - tut_io_pkg.sv
  - ps2_key_decoder.sv
  - dip_switch_bank.sv
  - cabinet_inputs.sv
  - color_ladder.sv
  - tut_io_top.sv
  - target: test
    files:
      - tb_tut_io.sv

// File: cabinet_inputs.sv
/*
 * Merges keyboard buttons, both joysticks and the DIP bytes into cabinet inputs.
 * All outputs are registered; most controls are active low as the game expects.
 */
module cabinet_inputs (
	input  logic                    CLK_49M,
	input  logic                    rst_n,
	input  tut_io_pkg::kb_buttons_t kb_buttons,
	input  tut_io_pkg::joy_t        joystick_0,
	input  tut_io_pkg::joy_t        joystick_1,
	input  logic [15:0]             dip_bytes,
	output logic [1:0]              coin,
	output logic [1:0]              start_buttons,
	output logic [1:0]              fire_right,
	output logic [1:0]              flash_bomb,
	output logic [3:0]              p1_joystick,
	output logic [3:0]              p2_joystick,
	output logic                    p1_fire,
	output logic                    p2_fire,
	output logic                    service,
	output logic                    pause_button,
	output logic [15:0]             dip_sw
);
	import tut_io_pkg::*;

	// ==================================================
	// Merged controls, active high
	// ==================================================
	// Player 1 takes keyboard and joystick 0
	logic up_1, down_1, left_1, right_1, fire_1;
	// Player 2 is joystick 1 only
	logic up_2, down_2, left_2, right_2, fire_2;
	logic coin_1, coin_2, start_1, start_2, pause_m;

	assign up_1    = kb_buttons[KB_UP]    | joystick_0[JOY_UP];
	assign down_1  = kb_buttons[KB_DOWN]  | joystick_0[JOY_DOWN];
	assign left_1  = kb_buttons[KB_LEFT]  | joystick_0[JOY_LEFT];
	assign right_1 = kb_buttons[KB_RIGHT] | joystick_0[JOY_RIGHT];
	assign fire_1  = kb_buttons[KB_FIRE]  | joystick_0[JOY_FIRE_L];

	assign up_2    = joystick_1[JOY_UP];
	assign down_2  = joystick_1[JOY_DOWN];
	assign left_2  = joystick_1[JOY_LEFT];
	assign right_2 = joystick_1[JOY_RIGHT];
	assign fire_2  = joystick_1[JOY_FIRE_L];

	// Coin 2 has no joystick button
	assign coin_1  = kb_buttons[KB_COIN1]  | joystick_0[JOY_COIN];
	assign coin_2  = kb_buttons[KB_COIN2];
	assign start_1 = kb_buttons[KB_START1] | joystick_0[JOY_START];
	assign start_2 = kb_buttons[KB_START2] | joystick_0[JOY_START2];
	assign pause_m = kb_buttons[KB_PAUSE]  | joystick_0[JOY_PAUSE];

	// ==================================================
	// Output registers with cabinet polarity
	// ==================================================
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			// Idle cabinet: active-low lines high, the rest low
			coin          <= 2'b11;
			start_buttons <= 2'b11;
			p1_joystick   <= 4'hF;
			p2_joystick   <= 4'hF;
			p1_fire       <= 1'b1;
			p2_fire       <= 1'b1;
			service       <= 1'b1;
			fire_right    <= 2'b00;
			flash_bomb    <= 2'b00;
			pause_button  <= 1'b0;
			dip_sw        <= 16'hFFFF;
		end else begin
			coin          <= ~{coin_2, coin_1};
			start_buttons <= ~{start_2, start_1};
			// Right, left, down, up from high bit to low
			p1_joystick   <= ~{right_1, left_1, down_1, up_1};
			p2_joystick   <= ~{right_2, left_2, down_2, up_2};
			p1_fire       <= ~fire_1;
			p2_fire       <= ~fire_2;
			service       <= ~kb_buttons[KB_SERVICE];
			// Player 2 in bit 1
			fire_right    <= {joystick_1[JOY_FIRE_R], joystick_0[JOY_FIRE_R]};
			flash_bomb    <= {joystick_1[JOY_FLASH], joystick_0[JOY_FLASH]};
			pause_button  <= pause_m;
			dip_sw        <= ~dip_bytes;
		end
	end

endmodule

// File: color_ladder.sv
/*
 * Converts the game's 5-bit colour channels to 8-bit levels.
 * Each set bit adds its resistor ladder weight; the packed colour is registered.
 */
module color_ladder (
	input  logic                 CLK_49M,
	input  logic                 rst_n,
	input  tut_io_pkg::chan_in_t video_r,
	input  tut_io_pkg::chan_in_t video_g,
	input  tut_io_pkg::chan_in_t video_b,
	output logic [23:0]          rgb_out
);
	import tut_io_pkg::*;

	chan_out_t level_r;
	chan_out_t level_g;
	chan_out_t level_b;

	// ==================================================
	// Weighted ladder
	// ==================================================
	// Sum of the weights of the set bits; the full sum is FFh, so no carry out
	function automatic chan_out_t ladder(input chan_in_t chan);
		chan_out_t acc;
		acc = '0;
		for (int i = 0; i < COLOR_IN_W; i++) begin
			if (chan[i]) begin
				acc = acc + COLOR_WEIGHT[i];
			end
		end
		return acc;
	endfunction

	assign level_r = ladder(video_r);
	assign level_g = ladder(video_g);
	assign level_b = ladder(video_b);

	// Red in the top byte, blue in the bottom
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			rgb_out <= '0;
		end else begin
			rgb_out <= {level_r, level_g, level_b};
		end
	end

endmodule

// File: dip_switch_bank.sv
/*
 * Holds the two DIP switch bytes loaded through the download channel.
 * Bytes are kept active low, exactly as downloaded.
 */
module dip_switch_bank (
	input  logic                              CLK_49M,
	input  logic                              rst_n,
	input  logic                              ioctl_wr,
	input  logic [7:0]                        ioctl_index,
	input  logic [tut_io_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                        ioctl_dout,
	output logic [15:0]                       dip_bytes
);
	import tut_io_pkg::*;

	logic dip_wr;
	logic byte_sel;

	// Only index 254 writes to address 0 or 1 reach the bank
	assign dip_wr   = ioctl_wr && (ioctl_index == DIP_INDEX) &&
		(ioctl_addr[IOCTL_ADDR_W-1:1] == '0);
	// Address bit 0 picks the byte
	assign byte_sel = ioctl_addr[0];

	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			dip_bytes <= '0;
		end else if (dip_wr) begin
			if (byte_sel) begin
				dip_bytes[15:8] <= ioctl_dout;
			end else begin
				dip_bytes[7:0] <= ioctl_dout;
			end
		end
	end

endmodule

// File: ps2_key_decoder.sv
/*
 * Turns framework key-event words into held keyboard button levels.
 * A change of the toggle bit marks a new event; the scan code picks the button.
 */
module ps2_key_decoder (
	input  logic                   CLK_49M,
	input  logic                   rst_n,
	input  tut_io_pkg::ps2_key_t   ps2_key,
	output tut_io_pkg::kb_buttons_t kb_buttons
);
	import tut_io_pkg::*;

	// Fields of the event word
	logic       key_toggle;
	logic       key_pressed;
	logic [7:0] scan_code;
	// Previous toggle bit
	logic       key_toggle_q;
	logic       key_event;

	assign key_toggle  = ps2_key[10];
	assign key_pressed = ps2_key[9];
	assign scan_code   = ps2_key[7:0];

	// Any toggle change is a new event, press or release
	assign key_event = key_toggle ^ key_toggle_q;

	// ==================================================
	// Event capture and button table
	// ==================================================
	always_ff @(posedge CLK_49M or negedge rst_n) begin
		if (!rst_n) begin
			key_toggle_q <= 1'b0;
			kb_buttons   <= '0;
		end else begin
			key_toggle_q <= key_toggle;
			// Button follows the pressed bit on the same edge as the event
			if (key_event) begin
				case (scan_code)
					// Start, coin and service row
					KEY_1:     kb_buttons[KB_START1]  <= key_pressed;
					KEY_2:     kb_buttons[KB_START2]  <= key_pressed;
					KEY_5:     kb_buttons[KB_COIN1]   <= key_pressed;
					KEY_6:     kb_buttons[KB_COIN2]   <= key_pressed;
					KEY_9:     kb_buttons[KB_SERVICE] <= key_pressed;
					KEY_P:     kb_buttons[KB_PAUSE]   <= key_pressed;
					// Cursor keys move player 1
					KEY_UP:    kb_buttons[KB_UP]      <= key_pressed;
					KEY_DOWN:  kb_buttons[KB_DOWN]    <= key_pressed;
					KEY_LEFT:  kb_buttons[KB_LEFT]    <= key_pressed;
					KEY_RIGHT: kb_buttons[KB_RIGHT]   <= key_pressed;
					KEY_CTRL:  kb_buttons[KB_FIRE]    <= key_pressed;
					// Keys outside the table leave every button alone
					default:   kb_buttons             <= kb_buttons;
				endcase
			end
		end
	end

endmodule

// File: sources.f
tut_io_pkg.sv
ps2_key_decoder.sv
dip_switch_bank.sv
cabinet_inputs.sv
color_ladder.sv
tut_io_top.sv
tb_tut_io.sv

// File: tb_tut_io.sv
/*
 * Self-checking testbench for the cabinet input and colour output path.
 * Concurrent assertions compare every output with the expected value each clock.
 */
module tb_tut_io;
	timeunit 1ns;
	timeprecision 100ps;
	import tut_io_pkg::*;

	localparam int unsigned SEED = 32'h8ff6_3074;
	localparam int MAX_CYCLES = 2000;

	logic CLK_49M, rst_n, ioctl_wr;
	ps2_key_t ps2_key;
	joy_t joystick_0, joystick_1;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	chan_in_t video_r, video_g, video_b;
	logic [1:0] coin, start_buttons, fire_right, flash_bomb;
	logic [3:0] p1_joystick, p2_joystick;
	logic p1_fire, p2_fire, service, pause_button;
	logic [15:0] dip_sw;
	logic [23:0] rgb_out;

	// Expected held keys and DIP bytes, set by the stimulus
	kb_buttons_t kb_exp;
	logic [15:0] dip_exp;
	logic key_toggle;
	int errors = 0;
	int cycles = 0;
	logic [7:0] key_codes [11] = '{KEY_1, KEY_2, KEY_5, KEY_6, KEY_9, KEY_P,
		KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_CTRL};

	tut_io_top UUT (
		.CLK_49M(CLK_49M), .rst_n(rst_n), .ps2_key(ps2_key),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .video_r(video_r), .video_g(video_g), .video_b(video_b),
		.coin(coin), .start_buttons(start_buttons), .p1_joystick(p1_joystick),
		.p2_joystick(p2_joystick), .p1_fire(p1_fire), .p2_fire(p2_fire),
		.fire_right(fire_right), .flash_bomb(flash_bomb), .service(service),
		.pause_button(pause_button), .dip_sw(dip_sw), .rgb_out(rgb_out)
	);

	always #5 CLK_49M = ~CLK_49M;

	// ==================================================
	// Reference rules
	// ==================================================
	// Scan code table, -1 for keys the cabinet ignores
	function automatic int button_for_code(input logic [7:0] code);
		case (code)
			KEY_1: return KB_START1;
			KEY_2: return KB_START2;
			KEY_5: return KB_COIN1;
			KEY_6: return KB_COIN2;
			KEY_9: return KB_SERVICE;
			KEY_P: return KB_PAUSE;
			KEY_UP: return KB_UP;
			KEY_DOWN: return KB_DOWN;
			KEY_LEFT: return KB_LEFT;
			KEY_RIGHT: return KB_RIGHT;
			KEY_CTRL: return KB_FIRE;
			default: return -1;
		endcase
	endfunction

	// Active-low stick: right, left, down, up from high bit to low
	function automatic logic [3:0] stick_low(input kb_buttons_t kb, input joy_t joy);
		return ~{kb[KB_RIGHT] | joy[JOY_RIGHT], kb[KB_LEFT] | joy[JOY_LEFT],
			kb[KB_DOWN] | joy[JOY_DOWN], kb[KB_UP] | joy[JOY_UP]};
	endfunction

	function automatic chan_out_t weighted_level(input chan_in_t chan);
		int sum;
		sum = 0;
		for (int b = 0; b < COLOR_IN_W; b++) begin
			if (chan[b]) sum = sum + int'(COLOR_WEIGHT[b]);
		end
		return chan_out_t'(sum);
	endfunction

	task automatic report_mismatch(input string what);
		errors++;
		$display("** Error at %0t ns: %s", $time, what);
	endtask

	// ==================================================
	// Checks, keyboard 2 edges, joystick and colour 1 edge
	// ==================================================
	reset_idle: assert property (@(posedge CLK_49M) (cycles > 0 && (!rst_n || !$past(rst_n))) |->
		(coin == 2'b11 && start_buttons == 2'b11 && p1_joystick == 4'hF &&
		p2_joystick == 4'hF && p1_fire && p2_fire && service && fire_right == 2'b00 &&
		flash_bomb == 2'b00 && !pause_button && dip_sw == 16'hFFFF && rgb_out == '0))
		else report_mismatch("outputs not idle around reset");
	p1_stick_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		p1_joystick == stick_low($past(kb_exp, 2), $past(joystick_0)))
		else report_mismatch("p1_joystick mismatch");
	p2_stick_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		p2_joystick == stick_low('0, $past(joystick_1)))
		else report_mismatch("p2_joystick mismatch");
	fire_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		p1_fire == ~($past(kb_exp[KB_FIRE], 2) | $past(joystick_0[JOY_FIRE_L])) &&
		p2_fire == ~$past(joystick_1[JOY_FIRE_L]))
		else report_mismatch("p1_fire or p2_fire mismatch");
	coin_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		coin == ~{$past(kb_exp[KB_COIN2], 2),
		$past(kb_exp[KB_COIN1], 2) | $past(joystick_0[JOY_COIN])})
		else report_mismatch("coin mismatch");
	start_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		start_buttons == ~{$past(kb_exp[KB_START2], 2) | $past(joystick_0[JOY_START2]),
		$past(kb_exp[KB_START1], 2) | $past(joystick_0[JOY_START])})
		else report_mismatch("start_buttons mismatch");
	service_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		service == ~$past(kb_exp[KB_SERVICE], 2))
		else report_mismatch("service mismatch");
	pause_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		pause_button == ($past(kb_exp[KB_PAUSE], 2) | $past(joystick_0[JOY_PAUSE])))
		else report_mismatch("pause_button mismatch");
	// Player 2 in bit 1
	buttons_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		fire_right == {$past(joystick_1[JOY_FIRE_R]), $past(joystick_0[JOY_FIRE_R])} &&
		flash_bomb == {$past(joystick_1[JOY_FLASH]), $past(joystick_0[JOY_FLASH])})
		else report_mismatch("fire_right or flash_bomb mismatch");
	dip_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		dip_sw == ~$past(dip_exp, 2))
		else report_mismatch("dip_sw mismatch");
	color_ok: assert property (@(posedge CLK_49M) disable iff (!rst_n)
		rgb_out == {weighted_level($past(video_r)), weighted_level($past(video_g)),
		weighted_level($past(video_b))})
		else report_mismatch("rgb_out mismatch");

	// ==================================================
	// Stimulus tasks, all on the falling edge
	// ==================================================
	// New event with a flipped toggle
	task automatic send_key(input logic [7:0] code, input logic pressed);
		int idx;
		@(negedge CLK_49M);
		key_toggle = ~key_toggle;
		ps2_key = {key_toggle, pressed, 1'b0, code};
		idx = button_for_code(code);
		if (idx >= 0) kb_exp[idx] = pressed;
		repeat (3) @(negedge CLK_49M);
	endtask

	// Same toggle, so no event
	task automatic resend_key(input logic [7:0] code, input logic pressed);
		@(negedge CLK_49M);
		ps2_key = {key_toggle, pressed, 1'b0, code};
		repeat (3) @(negedge CLK_49M);
	endtask

	task automatic hold_and_toggle(input logic [7:0] code, input int joy_bit);
		send_key(code, 1'b1);
		joystick_0[joy_bit] = 1'b1;
		repeat (2) @(negedge CLK_49M);
		joystick_0[joy_bit] = 1'b0;
		send_key(code, 1'b0);
		joystick_0[joy_bit] = 1'b1;
		repeat (2) @(negedge CLK_49M);
		joystick_0[joy_bit] = 1'b0;
	endtask

	task automatic dip_write(input logic [7:0] index, input int addr, input logic [7:0] data);
		@(negedge CLK_49M);
		ioctl_wr = 1'b1;
		ioctl_index = index;
		ioctl_addr = addr[IOCTL_ADDR_W-1:0];
		ioctl_dout = data;
		if (index == DIP_INDEX && addr == 0) dip_exp[7:0] = data;
		if (index == DIP_INDEX && addr == 1) dip_exp[15:8] = data;
		@(negedge CLK_49M);
		ioctl_wr = 1'b0;
		repeat (2) @(negedge CLK_49M);
	endtask

	// Watchdog
	always @(posedge CLK_49M) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		CLK_49M = 1'b0;
		rst_n = 1'b0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		video_r = '0;
		video_g = '0;
		video_b = '0;
		kb_exp = '0;
		dip_exp = '0;
		key_toggle = 1'b0;
		void'($urandom(SEED));
		repeat (5) @(negedge CLK_49M);
		rst_n = 1'b1;
		// Every table key pressed then released
		foreach (key_codes[i]) begin
			send_key(key_codes[i], 1'b1);
			send_key(key_codes[i], 1'b0);
		end
		// Unknown code, then a repeat with no toggle change
		send_key(8'h1C, 1'b1);
		send_key(KEY_UP, 1'b1);
		resend_key(KEY_UP, 1'b0);
		send_key(KEY_UP, 1'b0);
		// Joystick words with the keyboard idle
		repeat (100) begin
			@(negedge CLK_49M);
			joystick_0 = joy_t'($urandom);
			joystick_1 = joy_t'($urandom);
		end
		@(negedge CLK_49M);
		joystick_0 = '0;
		joystick_1 = '0;
		// Keyboard and joystick on one control
		hold_and_toggle(KEY_5, JOY_COIN);
		hold_and_toggle(KEY_6, JOY_COIN);
		hold_and_toggle(KEY_9, JOY_START);
		hold_and_toggle(KEY_1, JOY_START);
		hold_and_toggle(KEY_2, JOY_START2);
		hold_and_toggle(KEY_P, JOY_PAUSE);
		hold_and_toggle(KEY_LEFT, JOY_LEFT);
		hold_and_toggle(KEY_CTRL, JOY_FIRE_L);
		// DIP bank, valid and ignored writes
		dip_write(DIP_INDEX, 0, 8'($urandom));
		dip_write(DIP_INDEX, 1, 8'($urandom));
		dip_write(8'd0, 0, 8'($urandom));
		dip_write(DIP_INDEX, 2, 8'($urandom));
		dip_write(DIP_INDEX, 25'h100001, 8'($urandom));
		// Colour sweep covers all 32 codes on each channel
		for (int v = 0; v < 32; v++) begin
			@(negedge CLK_49M);
			video_r = chan_in_t'(v);
			video_g = chan_in_t'(31 - v);
			video_b = chan_in_t'(v ^ 21);
		end
		repeat (64) begin
			@(negedge CLK_49M);
			video_r = chan_in_t'($urandom);
			video_g = chan_in_t'($urandom);
			video_b = chan_in_t'($urandom);
		end
		repeat (4) @(negedge CLK_49M);
		$display("Assertion failures: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: tut_io_pkg.sv
/*
 * Shared widths, vector types, key codes and bit positions for the cabinet I/O path.
 * Modules take names from here by a wildcard import inside their body.
 */
package tut_io_pkg;

	// ==================================================
	// Widths and vector types
	// ==================================================
	localparam int PS2_KEY_W    = 11;
	localparam int JOY_W        = 16;
	localparam int IOCTL_ADDR_W = 25;
	localparam int COLOR_IN_W   = 5;
	localparam int COLOR_OUT_W  = 8;
	localparam int KB_W         = 11;

	// Bit 10 toggles per event, bit 9 is pressed, bits 7..0 scan code
	typedef logic [PS2_KEY_W-1:0]   ps2_key_t;
	typedef logic [JOY_W-1:0]       joy_t;
	typedef logic [COLOR_IN_W-1:0]  chan_in_t;
	typedef logic [COLOR_OUT_W-1:0] chan_out_t;
	typedef logic [KB_W-1:0]        kb_buttons_t;

	// ==================================================
	// Keyboard button positions and scan codes
	// ==================================================
	localparam int KB_UP      = 0;
	localparam int KB_DOWN    = 1;
	localparam int KB_LEFT    = 2;
	localparam int KB_RIGHT   = 3;
	localparam int KB_FIRE    = 4;
	localparam int KB_COIN1   = 5;
	localparam int KB_COIN2   = 6;
	localparam int KB_START1  = 7;
	localparam int KB_START2  = 8;
	localparam int KB_PAUSE   = 9;
	localparam int KB_SERVICE = 10;

	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1E;
	localparam logic [7:0] KEY_5     = 8'h2E;
	localparam logic [7:0] KEY_6     = 8'h36;
	localparam logic [7:0] KEY_9     = 8'h46;
	localparam logic [7:0] KEY_P     = 8'h4D;
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	// Left control key fires
	localparam logic [7:0] KEY_CTRL  = 8'h14;

	// Framework joystick word layout
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_L = 4;
	localparam int JOY_FIRE_R = 5;
	localparam int JOY_FLASH  = 6;
	localparam int JOY_COIN   = 7;
	localparam int JOY_START  = 8;
	localparam int JOY_START2 = 9;
	localparam int JOY_PAUSE  = 10;

	// ==================================================
	// DIP download index and colour ladder
	// ==================================================
	localparam logic [7:0] DIP_INDEX = 8'd254;

	// Resistor ladder weights listed from bit 4 down to bit 0
	// They add up to FFh
	localparam logic [COLOR_IN_W-1:0][COLOR_OUT_W-1:0] COLOR_WEIGHT =
		'{8'h4D, 8'h40, 8'h35, 8'h24, 8'h19};

endpackage

// File: tut_io_top.sv
/*
 * Top of the cabinet input and colour output path.
 * Keyboard and DIP bank feed the input merger; the colour ladder sits alongside.
 */
module tut_io_top (
	input  logic                                CLK_49M,
	input  logic                                rst_n,
	input  tut_io_pkg::ps2_key_t                ps2_key,
	input  tut_io_pkg::joy_t                    joystick_0,
	input  tut_io_pkg::joy_t                    joystick_1,
	input  logic                                ioctl_wr,
	input  logic [7:0]                          ioctl_index,
	input  logic [tut_io_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                          ioctl_dout,
	input  tut_io_pkg::chan_in_t                video_r,
	input  tut_io_pkg::chan_in_t                video_g,
	input  tut_io_pkg::chan_in_t                video_b,
	output logic [1:0]                          coin,
	output logic [1:0]                          start_buttons,
	output logic [3:0]                          p1_joystick,
	output logic [3:0]                          p2_joystick,
	output logic                                p1_fire,
	output logic                                p2_fire,
	output logic [1:0]                          fire_right,
	output logic [1:0]                          flash_bomb,
	output logic                                service,
	output logic                                pause_button,
	output logic [15:0]                         dip_sw,
	output logic [23:0]                         rgb_out
);
	import tut_io_pkg::*;

	// Held keys, one bit per button
	kb_buttons_t kb_buttons;
	// Raw DIP bytes, still active low
	logic [15:0] dip_bytes;

	// ==================================================
	// Input path
	// ==================================================
	ps2_key_decoder u_key (
		.CLK_49M    (CLK_49M),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.kb_buttons (kb_buttons)
	);

	dip_switch_bank u_dip (
		.CLK_49M     (CLK_49M),
		.rst_n       (rst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_bytes   (dip_bytes)
	);

	cabinet_inputs u_cab (
		.CLK_49M       (CLK_49M),
		.rst_n         (rst_n),
		.kb_buttons    (kb_buttons),
		.joystick_0    (joystick_0),
		.joystick_1    (joystick_1),
		.dip_bytes     (dip_bytes),
		.coin          (coin),
		.start_buttons (start_buttons),
		.fire_right    (fire_right),
		.flash_bomb    (flash_bomb),
		.p1_joystick   (p1_joystick),
		.p2_joystick   (p2_joystick),
		.p1_fire       (p1_fire),
		.p2_fire       (p2_fire),
		.service       (service),
		.pause_button  (pause_button),
		.dip_sw        (dip_sw)
	);

	// Colour output
	color_ladder u_color (
		.CLK_49M (CLK_49M),
		.rst_n   (rst_n),
		.video_r (video_r),
		.video_g (video_g),
		.video_b (video_b),
		.rgb_out (rgb_out)
	);

endmodule
